// File: rtl/coreMemPkg.sv
//--------------------------------------------------------------------
// Word types, memory sizes, region map and control-register offsets
// for the core memory subsystem
//--------------------------------------------------------------------
package coreMemPkg;

    //------------------------------------------------------------------
    // Basic vector types
    //------------------------------------------------------------------
    // Data or instruction word
    typedef logic [31:0] word_t;
    // Byte address from the core
    typedef logic [31:0] addr_t;
    // One enable per byte lane
    typedef logic [3:0]  byteEn_t;

    //------------------------------------------------------------------
    // Memory sizes
    //------------------------------------------------------------------
    // Word index width, 1024 words each
    localparam int iMemAddrW = 10;
    localparam int dMemAddrW = 10;

    //------------------------------------------------------------------
    // Region map over address bits 31:12
    //------------------------------------------------------------------
    localparam int regionMsb = 31;
    localparam int regionLsb = 12;

    // Data memory at 0x0001_0000 .. 0x0001_0FFF
    localparam logic [regionMsb-regionLsb:0] dMemRegionFloor  = 20'h00010;
    localparam logic [regionMsb-regionLsb:0] dMemRegionRoof   = 20'h00010;
    // Control registers at 0x0002_0000 .. 0x0002_0FFF
    localparam logic [regionMsb-regionLsb:0] crMemRegionFloor = 20'h00020;
    localparam logic [regionMsb-regionLsb:0] crMemRegionRoof  = 20'h00020;

    //------------------------------------------------------------------
    // Control-register offsets
    //------------------------------------------------------------------
    // Digits 0 to 3, digit 0 in the low byte
    localparam logic [7:0] crSeg7Lo = 8'h00;
    // Digits 4 and 5 in the low two bytes
    localparam logic [7:0] crSeg7Hi = 8'h04;
    // 10 LED bits
    localparam logic [7:0] crLed    = 8'h08;
    // Read only, Button_1 in bit 1 and Button_0 in bit 0
    localparam logic [7:0] crButton = 8'h0C;
    // Read only, 10 switch bits
    localparam logic [7:0] crSwitch = 8'h10;

endpackage

// File: rtl/instrMem.sv
//--------------------------------------------------------------------
// Instruction memory with fetch read port and loader write port
//--------------------------------------------------------------------
`timescale 1ns/1ps

module instrMem (
    input  logic                                Clk,
    // Fetch side
    input  logic [coreMemPkg::iMemAddrW-1:0]    rdAddress,
    output coreMemPkg::word_t                   rdData,
    // Loader side
    input  logic                                wrEn,
    input  logic [coreMemPkg::iMemAddrW-1:0]    wrAddress,
    input  coreMemPkg::word_t                   wrData
);

    // Instruction storage, contents not reset
    coreMemPkg::word_t mem [0:(1 << coreMemPkg::iMemAddrW)-1];

    //------------------------------------------------------------------
    // Loader write port
    //------------------------------------------------------------------
    // Takes effect at the edge where wrEn is high
    always_ff @(posedge Clk) begin
        if (wrEn) begin
            mem[wrAddress] <= wrData;
        end
    end

    //------------------------------------------------------------------
    // Fetch read port
    //------------------------------------------------------------------
    // Read every cycle, one cycle latency from Q100H to Q101H
    // Same-address write returns the old word
    always_ff @(posedge Clk) begin
        rdData <= mem[rdAddress];
    end

endmodule

// File: rtl/dataMem.sv
//--------------------------------------------------------------------
// Word-addressed data memory with byte-lane writes and registered read
//--------------------------------------------------------------------
`timescale 1ns/1ps

module dataMem (
    input  logic                                Clk,
    // Word index, already region-decoded by the wrapper
    input  logic [coreMemPkg::dMemAddrW-1:0]    address,
    // Data and lane enables already shifted to the byte lane
    input  coreMemPkg::word_t                   wrData,
    input  coreMemPkg::byteEn_t                 byteEn,
    input  logic                                wrEn,
    input  logic                                rdEn,
    output coreMemPkg::word_t                   rdData
);

    // Data storage, contents not reset
    coreMemPkg::word_t mem [0:(1 << coreMemPkg::dMemAddrW)-1];

    //------------------------------------------------------------------
    // Byte-enabled write
    //------------------------------------------------------------------
    // Only the enabled lanes change
    // Lanes left clear keep their old byte
    always_ff @(posedge Clk) begin
        if (wrEn) begin
            for (int lane = 0; lane < $bits(coreMemPkg::byteEn_t); lane++) begin
                if (byteEn[lane]) begin
                    mem[address][8*lane +: 8] <= wrData[8*lane +: 8];
                end
            end
        end
    end

    //------------------------------------------------------------------
    // Registered read
    //------------------------------------------------------------------
    // Word captured at the end of Q103H, valid in Q104H
    // Holds the last word while rdEn is low
    // Read during write of the same word gives the old contents
    always_ff @(posedge Clk) begin
        if (rdEn) begin
            rdData <= mem[address];
        end
    end

endmodule

// File: rtl/crMem.sv
//--------------------------------------------------------------------
// Control-register file for seven-segment digits, LEDs, buttons and
// switches of the board
//--------------------------------------------------------------------
`timescale 1ns/1ps

module crMem (
    input  logic                    Clk,
    input  logic                    rst,
    // Core access, word offset within the region
    input  logic [7:0]              offset,
    input  coreMemPkg::word_t       wrData,
    input  logic                    wrEn,
    input  logic                    rdEn,
    output coreMemPkg::word_t       rdData,
    // Board inputs, asynchronous to Clk
    input  logic                    Button_0,
    input  logic                    Button_1,
    input  logic [9:0]              Switch,
    // Board outputs
    output logic [7:0]              SEG7_0,
    output logic [7:0]              SEG7_1,
    output logic [7:0]              SEG7_2,
    output logic [7:0]              SEG7_3,
    output logic [7:0]              SEG7_4,
    output logic [7:0]              SEG7_5,
    output logic [9:0]              LED
);

    // First and second synchroniser stages
    logic [1:0] buttonMeta;
    logic [1:0] buttonSync;
    logic [9:0] switchMeta;
    logic [9:0] switchSync;

    // Read data selected by offset
    coreMemPkg::word_t rdDataNext;

    //------------------------------------------------------------------
    // Board input synchroniser
    //------------------------------------------------------------------
    // Two flops per input bit
    // Value seen by a read is at least 3 cycles old
    always_ff @(posedge Clk) begin
        if (rst) begin
            buttonMeta <= '0;
            buttonSync <= '0;
            switchMeta <= '0;
            switchSync <= '0;
        end else begin
            buttonMeta <= {Button_1, Button_0};
            buttonSync <= buttonMeta;
            switchMeta <= Switch;
            switchSync <= switchMeta;
        end
    end

    //------------------------------------------------------------------
    // Writable registers
    //------------------------------------------------------------------
    // Whole-word writes by offset
    // Read-only and unused offsets fall through untouched
    always_ff @(posedge Clk) begin
        if (rst) begin
            SEG7_0 <= '0;
            SEG7_1 <= '0;
            SEG7_2 <= '0;
            SEG7_3 <= '0;
            SEG7_4 <= '0;
            SEG7_5 <= '0;
            LED    <= '0;
        end else if (wrEn) begin
            case (offset)
                coreMemPkg::crSeg7Lo: begin
                    SEG7_0 <= wrData[7:0];
                    SEG7_1 <= wrData[15:8];
                    SEG7_2 <= wrData[23:16];
                    SEG7_3 <= wrData[31:24];
                end
                coreMemPkg::crSeg7Hi: begin
                    // Upper two bytes have no digit behind them
                    SEG7_4 <= wrData[7:0];
                    SEG7_5 <= wrData[15:8];
                end
                coreMemPkg::crLed: begin
                    LED <= wrData[9:0];
                end
                default: ;
            endcase
        end
    end

    //------------------------------------------------------------------
    // Read path
    //------------------------------------------------------------------
    // Zero fill above each register, unused offsets read zero
    always_comb begin
        case (offset)
            coreMemPkg::crSeg7Lo: rdDataNext = {SEG7_3, SEG7_2, SEG7_1, SEG7_0};
            coreMemPkg::crSeg7Hi: rdDataNext = {16'b0, SEG7_5, SEG7_4};
            coreMemPkg::crLed:    rdDataNext = {22'b0, LED};
            coreMemPkg::crButton: rdDataNext = {30'b0, buttonSync};
            coreMemPkg::crSwitch: rdDataNext = {22'b0, switchSync};
            default:              rdDataNext = '0;
        endcase
    end

    // Registered response, valid the cycle after rdEn
    always_ff @(posedge Clk) begin
        if (rdEn) begin
            rdData <= rdDataNext;
        end
    end

endmodule

// File: rtl/coreMemWrap.sv
//--------------------------------------------------------------------
// Core memory wrapper with region decode, byte-lane shifting, Q104H
// stage and response mux over instruction, data and control memories
//--------------------------------------------------------------------
`timescale 1ns/1ps

module coreMemWrap (
    input  logic                    Clk,
    input  logic                    rst,
    // Instruction fetch
    input  coreMemPkg::addr_t       pcQ100H,
    output coreMemPkg::word_t       instructionQ101H,
    // Core data port
    input  coreMemPkg::addr_t       dMemAddressQ103H,
    input  coreMemPkg::word_t       dMemWrDataQ103H,
    input  coreMemPkg::byteEn_t     dMemByteEnQ103H,
    input  logic                    dMemWrEnQ103H,
    input  logic                    dMemRdEnQ103H,
    output coreMemPkg::word_t       dMemRdRspQ104H,
    // Boot loader port into the instruction memory
    input  logic                    iMemWrEn,
    input  coreMemPkg::addr_t       iMemWrAddress,
    input  coreMemPkg::word_t       iMemWrData,
    // Board inputs
    input  logic                    Button_0,
    input  logic                    Button_1,
    input  logic [9:0]              Switch,
    // Board outputs
    output logic [7:0]              SEG7_0,
    output logic [7:0]              SEG7_1,
    output logic [7:0]              SEG7_2,
    output logic [7:0]              SEG7_3,
    output logic [7:0]              SEG7_4,
    output logic [7:0]              SEG7_5,
    output logic [9:0]              LED
);

    // Region field of the data address
    logic [coreMemPkg::regionMsb-coreMemPkg::regionLsb:0] regionQ103H;

    // Region matches in both stages
    logic matchDMemRegionQ103H;
    logic matchDMemRegionQ104H;
    logic matchCrMemRegionQ103H;
    logic matchCrMemRegionQ104H;

    // Byte offset inside the word
    logic [1:0] byteOffsetQ103H;
    logic [1:0] byteOffsetQ104H;

    // Store data and enables moved to the addressed lane
    coreMemPkg::word_t   shiftWrDataQ103H;
    coreMemPkg::byteEn_t shiftByteEnQ103H;

    // Read words before and after the load shift
    coreMemPkg::word_t preShiftDMemRdDataQ104H;
    coreMemPkg::word_t dMemRdDataQ104H;
    coreMemPkg::word_t crRdDataQ104H;

    //------------------------------------------------------------------
    // Region decode
    //------------------------------------------------------------------
    assign regionQ103H     = dMemAddressQ103H[coreMemPkg::regionMsb:coreMemPkg::regionLsb];
    assign byteOffsetQ103H = dMemAddressQ103H[1:0];

    // One match per region, no match means unmapped
    always_comb begin
        matchDMemRegionQ103H  = (regionQ103H >= coreMemPkg::dMemRegionFloor) &&
                                (regionQ103H <= coreMemPkg::dMemRegionRoof);
        matchCrMemRegionQ103H = (regionQ103H >= coreMemPkg::crMemRegionFloor) &&
                                (regionQ103H <= coreMemPkg::crMemRegionRoof);
    end

    //------------------------------------------------------------------
    // Store lane shift
    //------------------------------------------------------------------
    // Data moves up 8k bits and enables up k lanes
    // Bits pushed past the top of the word are lost
    always_comb begin
        case (byteOffsetQ103H)
            2'b01: begin
                shiftWrDataQ103H = {dMemWrDataQ103H[23:0], 8'b0};
                shiftByteEnQ103H = {dMemByteEnQ103H[2:0], 1'b0};
            end
            2'b10: begin
                shiftWrDataQ103H = {dMemWrDataQ103H[15:0], 16'b0};
                shiftByteEnQ103H = {dMemByteEnQ103H[1:0], 2'b0};
            end
            2'b11: begin
                shiftWrDataQ103H = {dMemWrDataQ103H[7:0], 24'b0};
                shiftByteEnQ103H = {dMemByteEnQ103H[0], 3'b0};
            end
            default: begin
                shiftWrDataQ103H = dMemWrDataQ103H;
                shiftByteEnQ103H = dMemByteEnQ103H;
            end
        endcase
    end

    //------------------------------------------------------------------
    // Q103H to Q104H
    //------------------------------------------------------------------
    always_ff @(posedge Clk) begin
        if (rst) begin
            matchDMemRegionQ104H  <= 1'b0;
            matchCrMemRegionQ104H <= 1'b0;
        end else begin
            matchDMemRegionQ104H  <= matchDMemRegionQ103H;
            matchCrMemRegionQ104H <= matchCrMemRegionQ103H;
        end
    end

    // Offset only steers the load shift
    always_ff @(posedge Clk) begin
        byteOffsetQ104H <= byteOffsetQ103H;
    end

    //------------------------------------------------------------------
    // Load shift and response mux
    //------------------------------------------------------------------
    // Zero fill from the top, sign extension is left to the core
    always_comb begin
        case (byteOffsetQ104H)
            2'b01:   dMemRdDataQ104H = {8'b0,  preShiftDMemRdDataQ104H[31:8]};
            2'b10:   dMemRdDataQ104H = {16'b0, preShiftDMemRdDataQ104H[31:16]};
            2'b11:   dMemRdDataQ104H = {24'b0, preShiftDMemRdDataQ104H[31:24]};
            default: dMemRdDataQ104H = preShiftDMemRdDataQ104H;
        endcase
    end

    // Control registers first, then data, else unmapped zero
    assign dMemRdRspQ104H = matchCrMemRegionQ104H ? crRdDataQ104H   :
                            matchDMemRegionQ104H  ? dMemRdDataQ104H :
                                                    '0;

    //------------------------------------------------------------------
    // Memories
    //------------------------------------------------------------------
    // Word index taken from bits above the byte offset
    instrMem instrMem_i (
        .Clk       (Clk),
        .rdAddress (pcQ100H[coreMemPkg::iMemAddrW+1:2]),
        .rdData    (instructionQ101H),
        .wrEn      (iMemWrEn),
        .wrAddress (iMemWrAddress[coreMemPkg::iMemAddrW+1:2]),
        .wrData    (iMemWrData)
    );

    dataMem dataMem_i (
        .Clk     (Clk),
        .address (dMemAddressQ103H[coreMemPkg::dMemAddrW+1:2]),
        .wrData  (shiftWrDataQ103H),
        .byteEn  (shiftByteEnQ103H),
        .wrEn    (dMemWrEnQ103H && matchDMemRegionQ103H),
        .rdEn    (dMemRdEnQ103H && matchDMemRegionQ103H),
        .rdData  (preShiftDMemRdDataQ104H)
    );

    // Control registers see the unshifted word
    crMem crMem_i (
        .Clk      (Clk),
        .rst      (rst),
        .offset   (dMemAddressQ103H[7:0]),
        .wrData   (dMemWrDataQ103H),
        .wrEn     (dMemWrEnQ103H && matchCrMemRegionQ103H),
        .rdEn     (dMemRdEnQ103H && matchCrMemRegionQ103H),
        .rdData   (crRdDataQ104H),
        .Button_0 (Button_0),
        .Button_1 (Button_1),
        .Switch   (Switch),
        .SEG7_0   (SEG7_0),
        .SEG7_1   (SEG7_1),
        .SEG7_2   (SEG7_2),
        .SEG7_3   (SEG7_3),
        .SEG7_4   (SEG7_4),
        .SEG7_5   (SEG7_5),
        .LED      (LED)
    );

endmodule

// File: verif/coreMemWrapTb.sv
//----------------------------------------------------------------------
// Testbench for the core memory wrapper, stimulus table with shadow
// instruction, data and control-register models
//----------------------------------------------------------------------
`timescale 1ns/1ps

module coreMemWrapTb;

    typedef enum logic [2:0] {
        opIdle, opLoader, opFetch, opStore, opLoad, opBoard, opOuts
    } opKind_t;

    localparam int maxEntries  = 128;
    localparam int regionNone  = 0;
    localparam int regionData  = 1;
    localparam int regionCr    = 2;

    logic                Clk;
    logic                rst;
    coreMemPkg::addr_t   pcQ100H;
    coreMemPkg::word_t   instructionQ101H;
    coreMemPkg::addr_t   dMemAddressQ103H;
    coreMemPkg::word_t   dMemWrDataQ103H;
    coreMemPkg::byteEn_t dMemByteEnQ103H;
    logic                dMemWrEnQ103H;
    logic                dMemRdEnQ103H;
    coreMemPkg::word_t   dMemRdRspQ104H;
    logic                iMemWrEn;
    coreMemPkg::addr_t   iMemWrAddress;
    coreMemPkg::word_t   iMemWrData;
    logic                Button_0;
    logic                Button_1;
    logic [9:0]          Switch;
    logic [7:0]          SEG7_0;
    logic [7:0]          SEG7_1;
    logic [7:0]          SEG7_2;
    logic [7:0]          SEG7_3;
    logic [7:0]          SEG7_4;
    logic [7:0]          SEG7_5;
    logic [9:0]          LED;

    //------------------------------------------------------------------
    // Stimulus table and shadow models
    //------------------------------------------------------------------
    opKind_t     opTbl   [maxEntries];
    logic [31:0] addrTbl [maxEntries];
    logic [31:0] dataTbl [maxEntries];
    logic [3:0]  beTbl   [maxEntries];
    logic [63:0] expTbl  [maxEntries];
    int          testTbl [maxEntries];
    int          numEntries;

    logic [31:0] shadowI [1024];
    logic [31:0] shadowD [1024];
    // Control registers as the core should see them
    logic [31:0] seg7LoS;
    logic [15:0] seg7HiS;
    logic [9:0]  ledS;
    logic [1:0]  buttonS;
    logic [9:0]  switchS;

    int          checkCnt [1:6];
    int          errCnt   [1:6];
    string       testName [1:6];
    integer      seed;

    coreMemWrap coreMemWrap_i (
        .Clk (Clk), .rst (rst), .pcQ100H (pcQ100H), .instructionQ101H (instructionQ101H),
        .dMemAddressQ103H (dMemAddressQ103H), .dMemWrDataQ103H (dMemWrDataQ103H),
        .dMemByteEnQ103H (dMemByteEnQ103H), .dMemWrEnQ103H (dMemWrEnQ103H),
        .dMemRdEnQ103H (dMemRdEnQ103H), .dMemRdRspQ104H (dMemRdRspQ104H),
        .iMemWrEn (iMemWrEn), .iMemWrAddress (iMemWrAddress), .iMemWrData (iMemWrData),
        .Button_0 (Button_0), .Button_1 (Button_1), .Switch (Switch),
        .SEG7_0 (SEG7_0), .SEG7_1 (SEG7_1), .SEG7_2 (SEG7_2), .SEG7_3 (SEG7_3),
        .SEG7_4 (SEG7_4), .SEG7_5 (SEG7_5), .LED (LED)
    );

    // 10 ns clock
    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    // Region of a data-port address by the memory map
    function automatic int regionOf(input logic [31:0] addr);
        logic [19:0] field;
        field = addr[31:12];
        if (field >= coreMemPkg::dMemRegionFloor && field <= coreMemPkg::dMemRegionRoof)
            return regionData;
        if (field >= coreMemPkg::crMemRegionFloor && field <= coreMemPkg::crMemRegionRoof)
            return regionCr;
        return regionNone;
    endfunction

    // Store data and enables moved up k lanes, overflow dropped
    function automatic logic [31:0] laneMerge(input logic [31:0] oldWord,
                                              input logic [31:0] data,
                                              input logic [3:0] be, input int k);
        logic [31:0] result;
        logic [31:0] movedData;
        logic [3:0]  movedBe;
        result    = oldWord;
        movedData = data << (8 * k);
        movedBe   = be << k;
        for (int j = 0; j < 4; j++) begin
            if (movedBe[j]) result[8*j +: 8] = movedData[8*j +: 8];
        end
        return result;
    endfunction

    function automatic logic [31:0] crReadValue(input logic [7:0] off);
        logic [31:0] result;
        case (off)
            coreMemPkg::crSeg7Lo: result = seg7LoS;
            coreMemPkg::crSeg7Hi: result = {16'b0, seg7HiS};
            coreMemPkg::crLed:    result = {22'b0, ledS};
            coreMemPkg::crButton: result = {30'b0, buttonS};
            coreMemPkg::crSwitch: result = {22'b0, switchS};
            default:              result = '0;
        endcase
        return result;
    endfunction

    // All board outputs packed the same way as the table expects them
    function automatic logic [63:0] outputsWord();
        return {6'b0, LED, SEG7_5, SEG7_4, SEG7_3, SEG7_2, SEG7_1, SEG7_0};
    endfunction

    //------------------------------------------------------------------
    // Table building, shadow models updated in application order
    //------------------------------------------------------------------
    task automatic addEntry(input int testId, input opKind_t op, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] be);
        int          region;
        int          k;
        int          idx;
        logic [63:0] expVal;
        region = regionOf(addr);
        k      = addr[1:0];
        idx    = addr[11:2];
        expVal = '0;
        case (op)
            opLoader: shadowI[idx] = data;
            opFetch:  expVal = {32'b0, shadowI[idx]};
            opStore: begin
                if (region == regionData) begin
                    shadowD[idx] = laneMerge(shadowD[idx], data, be, k);
                end else if (region == regionCr) begin
                    // Whole-word writes, read-only offsets ignored
                    if (addr[7:0] == coreMemPkg::crSeg7Lo) seg7LoS = data;
                    if (addr[7:0] == coreMemPkg::crSeg7Hi) seg7HiS = data[15:0];
                    if (addr[7:0] == coreMemPkg::crLed)    ledS    = data[9:0];
                end
            end
            opLoad: begin
                if (region == regionData) expVal = {32'b0, shadowD[idx] >> (8 * k)};
                else if (region == regionCr) expVal = {32'b0, crReadValue(addr[7:0])};
            end
            opBoard: begin
                buttonS = data[17:16];
                switchS = data[9:0];
            end
            opOuts: expVal = {6'b0, ledS, seg7HiS, seg7LoS};
            default: ;
        endcase
        opTbl[numEntries]   = op;
        addrTbl[numEntries] = addr;
        dataTbl[numEntries] = data;
        beTbl[numEntries]   = be;
        expTbl[numEntries]  = expVal;
        testTbl[numEntries] = testId;
        numEntries++;
    endtask

    task automatic buildTable();
        logic [31:0] w;
        numEntries = 0;
        seg7LoS = '0;
        seg7HiS = '0;
        ledS    = '0;
        buttonS = '0;
        switchS = '0;
        // Outputs right after reset
        addEntry(1, opOuts, '0, '0, '0);
        // Loader fill, then back-to-back fetches in both orders
        for (int n = 0; n < 6; n++) begin
            w = $random(seed);
            addEntry(2, opLoader, 32'h40 + 4 * n, w, 4'hF);
        end
        for (int n = 0; n < 6; n++) addEntry(2, opFetch, 32'h40 + 4 * n, '0, '0);
        for (int n = 5; n >= 0; n--) addEntry(2, opFetch, 32'h40 + 4 * n, '0, '0);
        // Full words, loads pipelined one per cycle
        for (int n = 0; n < 6; n++) begin
            w = $random(seed);
            addEntry(3, opStore, 32'h0001_0000 + 8 * n, w, 4'hF);
        end
        for (int n = 0; n < 6; n++) addEntry(3, opLoad, 32'h0001_0000 + 8 * n, '0, '0);
        w = $random(seed);
        addEntry(3, opStore, 32'h0001_0FFC, w, 4'hF);
        addEntry(3, opLoad, 32'h0001_0FFC, '0, '0);
        // Byte and half-word lanes at offsets 1 to 3
        w = $random(seed);
        addEntry(4, opStore, 32'h0001_0200, w, 4'hF);
        w = $random(seed);
        addEntry(4, opStore, 32'h0001_0201, w, 4'b0001);
        addEntry(4, opLoad, 32'h0001_0201, '0, '0);
        w = $random(seed);
        addEntry(4, opStore, 32'h0001_0202, w, 4'b0011);
        addEntry(4, opLoad, 32'h0001_0202, '0, '0);
        w = $random(seed);
        addEntry(4, opStore, 32'h0001_0203, w, 4'b0001);
        addEntry(4, opLoad, 32'h0001_0203, '0, '0);
        addEntry(4, opLoad, 32'h0001_0200, '0, '0);
        w = $random(seed);
        addEntry(4, opStore, 32'h0001_0204, w, 4'hF);
        w = $random(seed);
        addEntry(4, opStore, 32'h0001_0205, w, 4'b0011);
        addEntry(4, opLoad, 32'h0001_0204, '0, '0);
        addEntry(4, opLoad, 32'h0001_0205, '0, '0);
        // Writable control registers
        for (int n = 0; n < 3; n++) begin
            w = $random(seed);
            addEntry(5, opStore, 32'h0002_0000 + 4 * n, w, 4'hF);
        end
        addEntry(5, opOuts, '0, '0, '0);
        for (int n = 0; n < 3; n++) addEntry(5, opLoad, 32'h0002_0000 + 4 * n, '0, '0);
        // Board inputs held across the synchroniser
        w = $random(seed);
        addEntry(5, opBoard, '0, {14'b0, 2'b10, 6'b0, w[9:0]}, '0);
        addEntry(5, opIdle, '0, '0, '0);
        addEntry(5, opIdle, '0, '0, '0);
        addEntry(5, opLoad, 32'h0002_000C, '0, '0);
        addEntry(5, opLoad, 32'h0002_0010, '0, '0);
        addEntry(5, opBoard, '0, {14'b0, 2'b01, 6'b0, ~w[9:0]}, '0);
        addEntry(5, opIdle, '0, '0, '0);
        addEntry(5, opIdle, '0, '0, '0);
        addEntry(5, opLoad, 32'h0002_000C, '0, '0);
        addEntry(5, opLoad, 32'h0002_0010, '0, '0);
        // Read-only and unused offsets
        w = $random(seed);
        addEntry(5, opStore, 32'h0002_000C, w, 4'hF);
        addEntry(5, opStore, 32'h0002_0010, w, 4'hF);
        addEntry(5, opOuts, '0, '0, '0);
        addEntry(5, opLoad, 32'h0002_000C, '0, '0);
        addEntry(5, opLoad, 32'h0002_0010, '0, '0);
        addEntry(5, opLoad, 32'h0002_0014, '0, '0);
        // Unmapped, aliases word 0 of data and the LED offset
        w = $random(seed);
        addEntry(6, opStore, 32'h0003_0000, w, 4'hF);
        addEntry(6, opStore, 32'h0003_0008, w, 4'hF);
        addEntry(6, opOuts, '0, '0, '0);
        addEntry(6, opLoad, 32'h0003_0000, '0, '0);
        addEntry(6, opLoad, 32'h0001_0000, '0, '0);
        addEntry(6, opLoad, 32'h0003_0008, '0, '0);
        addEntry(6, opLoad, 32'h0000_0040, '0, '0);
    endtask

    //------------------------------------------------------------------
    // Checks and reporting
    //------------------------------------------------------------------
    task automatic checkWord(input int testId, input string sigName,
                             input logic [63:0] expVal, input logic [63:0] actVal);
        checkCnt[testId]++;
        assert (actVal === expVal)
        else begin
            $display("MISMATCH time=%0t signal=%s expected=%h actual=%h",
                     $time, sigName, expVal, actVal);
            errCnt[testId]++;
        end
    endtask

    task automatic reportTest(input int testId);
        $display("Test %0d %s: %0d checks, %0d errors", testId, testName[testId],
                 checkCnt[testId], errCnt[testId]);
    endtask

    // Data port and loader quiet, board inputs keep their level
    task automatic driveIdle();
        dMemAddressQ103H = '0;
        dMemWrDataQ103H  = '0;
        dMemByteEnQ103H  = '0;
        dMemWrEnQ103H    = 1'b0;
        dMemRdEnQ103H    = 1'b0;
        iMemWrEn         = 1'b0;
        iMemWrAddress    = '0;
        iMemWrData       = '0;
    endtask

    initial begin
        opKind_t     pendOp;
        logic [63:0] pendExp;
        int          pendTest;
        int          curTest;
        int          totalChecks;
        int          totalErrs;
        rst      = 1'b1;
        pcQ100H  = '0;
        Button_0 = 1'b0;
        Button_1 = 1'b0;
        Switch   = '0;
        driveIdle();
        seed = 75;
        testName[1] = "reset values";
        testName[2] = "instruction fetch";
        testName[3] = "data word access";
        testName[4] = "sub-word access";
        testName[5] = "control registers";
        testName[6] = "unmapped addresses";
        for (int t = 1; t <= 6; t++) begin
            checkCnt[t] = 0;
            errCnt[t]   = 0;
        end
        buildTable();
        repeat (8) @(posedge Clk);
        #1 rst = 1'b0;
        pendOp   = opIdle;
        pendExp  = '0;
        pendTest = 1;
        curTest  = testTbl[0];
        // One entry per cycle, driven 1 ns after the edge
        for (int i = 0; i <= numEntries; i++) begin
            @(posedge Clk);
            #1;
            // Previous read answers in this cycle only
            if (pendOp == opFetch)
                checkWord(pendTest, "instructionQ101H", pendExp, {32'b0, instructionQ101H});
            else if (pendOp == opLoad)
                checkWord(pendTest, "dMemRdRspQ104H", pendExp, {32'b0, dMemRdRspQ104H});
            pendOp = opIdle;
            driveIdle();
            if (i < numEntries) begin
                if (testTbl[i] != curTest) begin
                    reportTest(curTest);
                    curTest = testTbl[i];
                end
                pendOp   = opTbl[i];
                pendExp  = expTbl[i];
                pendTest = testTbl[i];
                case (opTbl[i])
                    opLoader: begin
                        iMemWrEn      = 1'b1;
                        iMemWrAddress = addrTbl[i];
                        iMemWrData    = dataTbl[i];
                    end
                    opFetch: pcQ100H = addrTbl[i];
                    opStore: begin
                        dMemAddressQ103H = addrTbl[i];
                        dMemWrDataQ103H  = dataTbl[i];
                        dMemByteEnQ103H  = beTbl[i];
                        dMemWrEnQ103H    = 1'b1;
                    end
                    opLoad: begin
                        dMemAddressQ103H = addrTbl[i];
                        dMemRdEnQ103H    = 1'b1;
                    end
                    opBoard: begin
                        Button_0 = dataTbl[i][16];
                        Button_1 = dataTbl[i][17];
                        Switch   = dataTbl[i][9:0];
                    end
                    opOuts: begin
                        // Outputs follow the last write by exactly one cycle
                        checkWord(testTbl[i], "SEG7_5..SEG7_0,LED", expTbl[i], outputsWord());
                    end
                    default: ;
                endcase
            end
        end
        reportTest(curTest);
        totalChecks = 0;
        totalErrs   = 0;
        for (int t = 1; t <= 6; t++) begin
            totalChecks += checkCnt[t];
            totalErrs   += errCnt[t];
        end
        $display("Checks run: %0d, errors: %0d", totalChecks, totalErrs);
        if (totalErrs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: all.f
rtl/coreMemPkg.sv
rtl/instrMem.sv
rtl/dataMem.sv
rtl/crMem.sv
rtl/coreMemWrap.sv
verif/coreMemWrapTb.sv

// File: Bender.yml
package:
  name: core_mem_wrap

sources:
  - rtl/coreMemPkg.sv
  - rtl/instrMem.sv
  - rtl/dataMem.sv
  - rtl/crMem.sv
  - rtl/coreMemWrap.sv
  - target: simulation
    files:
      - verif/coreMemWrapTb.sv
